// ==== verilog/video_timing_pkg.sv ====
`default_nettype none

package video_timing_pkg;

    localparam int h_res  = 480;
    localparam int v_res  = 272;
    localparam int h_fp   = 2;
    localparam int h_sync = 41;
    localparam int h_bp   = 2;
    localparam int v_fp   = 2;
    localparam int v_sync = 10;
    localparam int v_bp   = 2;

    // line opens with blanking, the frame opens with active lines
    localparam int h_blank = h_fp + h_sync + h_bp;
    localparam int h_total = h_blank + h_res;
    localparam int v_total = v_res + v_fp + v_sync + v_bp;

    typedef struct packed {
        logic [9:0] x;          // wraps around during blanking
        logic [8:0] y;
        logic       de;
        logic       hs;         // active low
        logic       vs;         // active low
        logic       line_start;
    } beam_t;

endpackage

`default_nettype wire

// ==== verilog/tile_gfx_pkg.sv ====
`default_nettype none

package tile_gfx_pkg;

    localparam int vram_depth   = 4096;
    localparam int pattern_base = 0;     // 4 words per tile, even row in upper half
    localparam int palette_base = 1024;
    localparam int sprite_base  = 1056;
    localparam int map_base     = 2048;
    localparam int map_cols     = 60;
    localparam int max_sprites  = 16;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_ATTR,
        FETCH_PATTERN,
        FETCH_PALETTE,
        FETCH_MAP
    } fetch_kind_e;

    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        logic [7:0] tile;
        logic [4:0] palette;
        logic       behind_bg;
        logic       disabled;
    } sprite_attr_t;

    typedef struct packed {
        logic [7:0]  tile;
        logic [4:0]  palette;
        logic [18:0] reserved;
    } map_entry_t;

    typedef struct packed {
        logic       opaque;
        logic [7:0] color;   // rgb332
    } pixel_t;

    // colour k of a palette word sits in byte 3-k, index 0 is see-through
    function automatic pixel_t palette_pixel(logic [31:0] pal, logic [1:0] idx);
        pixel_t px;
        px.opaque = (idx != 2'd0);
        px.color  = pal[8*(3 - idx) +: 8];
        return px;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/vram.sv ====
`timescale 1ns/10ps
`default_nettype none

module vram
(
    input  wire         vga_clk,
    input  wire         wr_en,
    input  wire  [11:0] wr_addr,
    input  wire  [31:0] wr_data,
    input  wire         rd_en,
    input  wire  [11:0] rd_addr,
    output logic [31:0] rdata
);

    logic [31:0] mem [tile_gfx_pkg::vram_depth];

    always_ff @(posedge vga_clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rdata <= mem[rd_addr];   // one cycle read latency
    end

endmodule

`default_nettype wire

// ==== verilog/vram_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module vram_arbiter
(
    input  wire         vga_clk,
    input  wire         reset,
    input  wire         spr_req,
    input  wire  [11:0] spr_addr,
    output logic        spr_grant,
    input  wire         bg_req,
    input  wire  [11:0] bg_addr,
    output logic        bg_grant,
    output logic [31:0] rdata,
    input  wire         wr_en,
    input  wire  [11:0] wr_addr,
    input  wire  [31:0] wr_data
);

    // sprites always win, the address is taken in the grant cycle
    assign spr_grant = spr_req;
    assign bg_grant  = bg_req && !spr_req;

    vram i_vram
    (
        .vga_clk (vga_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (spr_req || bg_req),
        .rd_addr (spr_req ? spr_addr : bg_addr),
        .rdata   (rdata)
    );

    assert property (@(posedge vga_clk) disable iff (reset) !(spr_grant && bg_grant))
        else $error("both renderers granted in one cycle");

endmodule

`default_nettype wire

// ==== verilog/video_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_timing
(
    input  wire                       vga_clk,
    input  wire                       reset,
    output video_timing_pkg::beam_t   beam
);

    logic [9:0] h_count;
    logic [8:0] v_count;

    always_ff @(posedge vga_clk)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (h_count == 10'(video_timing_pkg::h_total - 1))
        begin
            h_count <= '0;
            if (v_count == 9'(video_timing_pkg::v_total - 1))
                v_count <= '0;
            else
                v_count <= v_count + 9'd1;
        end
        else
        begin
            h_count <= h_count + 10'd1;
        end
    end

    assign beam.x          = h_count - 10'(video_timing_pkg::h_blank);
    assign beam.y          = v_count;
    assign beam.de         = (h_count >= 10'(video_timing_pkg::h_blank)) &&
                             (v_count < 9'(video_timing_pkg::v_res));
    assign beam.hs         = !((h_count >= 10'(video_timing_pkg::h_fp)) &&
                               (h_count < 10'(video_timing_pkg::h_fp + video_timing_pkg::h_sync)));
    assign beam.vs         = !((v_count >= 9'(video_timing_pkg::v_res + video_timing_pkg::v_fp)) &&
                               (v_count < 9'(video_timing_pkg::v_total - video_timing_pkg::v_bp)));
    assign beam.line_start = (h_count == 10'd0);

    assert property (@(posedge vga_clk) disable iff (reset) $rose(beam.de) |-> beam.vs)
        else $error("de rose inside vertical sync");

endmodule

`default_nettype wire

// ==== verilog/sprite_renderer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_renderer
(
    input  wire                          vga_clk,
    input  wire                          reset,
    input  wire video_timing_pkg::beam_t beam,
    output logic                         vram_req,
    output logic [11:0]                  vram_addr,
    input  wire                          vram_grant,
    input  wire [31:0]                   vram_rdata,
    output tile_gfx_pkg::pixel_t         pixel,
    output logic                         behind_bg
);

    tile_gfx_pkg::sprite_attr_t attr_tab [tile_gfx_pkg::max_sprites];
    tile_gfx_pkg::pixel_t       row_px [tile_gfx_pkg::max_sprites][8];

    tile_gfx_pkg::fetch_kind_e state;
    tile_gfx_pkg::fetch_kind_e pend_kind;
    logic [3:0]                idx;
    logic [3:0]                pend_idx;
    logic                      pend;
    logic                      pend_half;
    logic [15:0]               pat_hold;
    logic [8:0]                fetch_dy;
    logic [9:0]                dx;
    logic [8:0]                dy;
    tile_gfx_pkg::pixel_t      hit_px;
    logic                      hit_behind;
    tile_gfx_pkg::pixel_t      s1_px;
    logic                      s1_behind;

    assign fetch_dy = beam.y - 9'(attr_tab[idx].y);
    assign vram_req = (state != tile_gfx_pkg::FETCH_IDLE);

    always_comb
    begin
        case (state)
            tile_gfx_pkg::FETCH_ATTR:
                vram_addr = 12'(tile_gfx_pkg::sprite_base + idx);
            tile_gfx_pkg::FETCH_PATTERN:
                vram_addr = 12'(tile_gfx_pkg::pattern_base + attr_tab[idx].tile * 4 + fetch_dy[2:1]);
            tile_gfx_pkg::FETCH_PALETTE:
                vram_addr = 12'(tile_gfx_pkg::palette_base + attr_tab[idx].palette);
            default:
                vram_addr = '0;
        endcase
    end

    always_ff @(posedge vga_clk)
    begin
        if (reset)
        begin
            state <= tile_gfx_pkg::FETCH_IDLE;
            idx   <= '0;
            pend  <= 1'b0;
        end
        else
        begin
            pend <= vram_grant;
            if (beam.line_start)
            begin
                idx <= '0;
                // table reload on the last blanking line, row fetch on all others
                if (beam.y == 9'(video_timing_pkg::v_total - 1))
                    state <= tile_gfx_pkg::FETCH_ATTR;
                else
                    state <= tile_gfx_pkg::FETCH_PATTERN;
            end
            else if (vram_grant)
            begin
                case (state)
                    tile_gfx_pkg::FETCH_ATTR, tile_gfx_pkg::FETCH_PALETTE:
                    begin
                        idx <= idx + 4'd1;
                        if (idx == 4'(tile_gfx_pkg::max_sprites - 1))
                            state <= tile_gfx_pkg::FETCH_IDLE;
                        else if (state == tile_gfx_pkg::FETCH_PALETTE)
                            state <= tile_gfx_pkg::FETCH_PATTERN;
                    end
                    tile_gfx_pkg::FETCH_PATTERN:
                        state <= tile_gfx_pkg::FETCH_PALETTE;
                    default:
                        state <= tile_gfx_pkg::FETCH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge vga_clk)
    begin
        pend_kind <= state;
        pend_idx  <= idx;
        pend_half <= fetch_dy[0];  // odd rows in the lower half-word
        if (pend)
        begin
            case (pend_kind)
                tile_gfx_pkg::FETCH_ATTR:
                    attr_tab[pend_idx] <= vram_rdata;
                tile_gfx_pkg::FETCH_PATTERN:
                    pat_hold <= pend_half ? vram_rdata[15:0] : vram_rdata[31:16];
                tile_gfx_pkg::FETCH_PALETTE:
                    for (int i = 0; i < 8; i++)
                        row_px[pend_idx][i] <=
                            tile_gfx_pkg::palette_pixel(vram_rdata, pat_hold[15 - 2*i -: 2]);
                default: ;
            endcase
        end
        s1_px     <= hit_px;
        s1_behind <= hit_behind;
        pixel     <= s1_px;
        behind_bg <= s1_behind;
    end

    // walk downward so the lowest index is written last
    always_comb
    begin
        hit_px     = '0;
        hit_behind = 1'b0;
        for (int s = tile_gfx_pkg::max_sprites - 1; s >= 0; s--)
        begin
            dx = beam.x - 10'(attr_tab[s].x);
            dy = beam.y - 9'(attr_tab[s].y);
            if (!attr_tab[s].disabled && dx < 10'd8 && dy < 9'd8 &&
                row_px[s][dx[2:0]].opaque)
            begin
                hit_px     = row_px[s][dx[2:0]];
                hit_behind = attr_tab[s].behind_bg;
            end
        end
    end

    assert property (@(posedge vga_clk) disable iff (reset) vram_grant |-> vram_req)
        else $error("sprite grant without request");

endmodule

`default_nettype wire

// ==== verilog/bg_renderer.sv ====
`timescale 1ns/10ps
`default_nettype none

module bg_renderer
(
    input  wire                          vga_clk,
    input  wire                          reset,
    input  wire video_timing_pkg::beam_t beam,
    output logic                         vram_req,
    output logic [11:0]                  vram_addr,
    input  wire                          vram_grant,
    input  wire [31:0]                   vram_rdata,
    output tile_gfx_pkg::pixel_t         pixel
);

    tile_gfx_pkg::fetch_kind_e state;
    tile_gfx_pkg::fetch_kind_e pend_kind;
    logic                      pend;
    logic                      tile_start;
    logic                      last_col;
    logic [5:0]                fetch_col;
    logic [8:0]                fetch_line;
    tile_gfx_pkg::map_entry_t  map_q;
    logic [15:0]               nxt_pattern;
    logic [31:0]               nxt_palette;
    logic [15:0]               shift_pat;
    logic [31:0]               cur_pal;
    tile_gfx_pkg::pixel_t      s1_px;

    assign tile_start = beam.de && (beam.x[2:0] == 3'd0);
    assign last_col   = (beam.x[9:3] == 7'(tile_gfx_pkg::map_cols - 1));
    // hold off while the map entry is still in flight
    assign vram_req   = (state != tile_gfx_pkg::FETCH_IDLE) &&
                        !(pend && pend_kind == tile_gfx_pkg::FETCH_MAP);

    always_comb
    begin
        case (state)
            tile_gfx_pkg::FETCH_MAP:
                vram_addr = 12'(tile_gfx_pkg::map_base +
                                fetch_line[8:3] * tile_gfx_pkg::map_cols + fetch_col);
            tile_gfx_pkg::FETCH_PATTERN:
                vram_addr = 12'(tile_gfx_pkg::pattern_base + map_q.tile * 4 + fetch_line[2:1]);
            tile_gfx_pkg::FETCH_PALETTE:
                vram_addr = 12'(tile_gfx_pkg::palette_base + map_q.palette);
            default:
                vram_addr = '0;
        endcase
    end

    always_ff @(posedge vga_clk)
    begin
        if (reset)
        begin
            state <= tile_gfx_pkg::FETCH_IDLE;
            pend  <= 1'b0;
        end
        else
        begin
            pend <= vram_grant;
            if (tile_start)
                state <= tile_gfx_pkg::FETCH_MAP;
            else if (vram_grant)
            begin
                case (state)
                    tile_gfx_pkg::FETCH_MAP:     state <= tile_gfx_pkg::FETCH_PATTERN;
                    tile_gfx_pkg::FETCH_PATTERN: state <= tile_gfx_pkg::FETCH_PALETTE;
                    default:                     state <= tile_gfx_pkg::FETCH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge vga_clk)
    begin
        pend_kind <= state;
        if (tile_start)
        begin
            // the last column prefetches tile 0 of the following line
            fetch_col <= last_col ? 6'd0 : 6'(beam.x[9:3] + 7'd1);
            if (!last_col)
                fetch_line <= beam.y;
            else if (beam.y == 9'(video_timing_pkg::v_res - 1))
                fetch_line <= '0;
            else
                fetch_line <= beam.y + 9'd1;
        end
        if (pend)
        begin
            case (pend_kind)
                tile_gfx_pkg::FETCH_MAP:
                    map_q <= vram_rdata;
                tile_gfx_pkg::FETCH_PATTERN:
                    nxt_pattern <= fetch_line[0] ? vram_rdata[15:0] : vram_rdata[31:16];
                tile_gfx_pkg::FETCH_PALETTE:
                    nxt_palette <= vram_rdata;
                default: ;
            endcase
        end
        if (beam.x[2:0] == 3'd7)
        begin
            shift_pat <= nxt_pattern;
            cur_pal   <= nxt_palette;
        end
        else
        begin
            shift_pat <= {shift_pat[13:0], 2'b00};
        end
        s1_px <= tile_gfx_pkg::palette_pixel(cur_pal, shift_pat[15:14]);
        pixel <= s1_px;
    end

endmodule

`default_nettype wire

// ==== verilog/pixel_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_mixer
(
    input  wire                          vga_clk,
    input  wire                          reset,
    input  wire video_timing_pkg::beam_t beam,
    input  wire tile_gfx_pkg::pixel_t    spr_pixel,
    input  wire                          spr_behind_bg,
    input  wire tile_gfx_pkg::pixel_t    bg_pixel,
    output logic [2:0]                   vga_r,
    output logic [2:0]                   vga_g,
    output logic [1:0]                   vga_b,
    output logic                         vga_hs,
    output logic                         vga_vs,
    output logic                         vga_de
);

    logic [1:0] de_d;
    logic [1:0] hs_d;
    logic [1:0] vs_d;
    logic [7:0] color;

    // syncs follow the two renderer pipeline stages
    always_ff @(posedge vga_clk)
    begin
        if (reset)
        begin
            de_d <= 2'b00;
            hs_d <= 2'b11;
            vs_d <= 2'b11;
        end
        else
        begin
            de_d <= {de_d[0], beam.de};
            hs_d <= {hs_d[0], beam.hs};
            vs_d <= {vs_d[0], beam.vs};
        end
    end

    assign vga_de = de_d[1];
    assign vga_hs = hs_d[1];
    assign vga_vs = vs_d[1];

    always_comb
    begin
        if (spr_pixel.opaque && !(spr_behind_bg && bg_pixel.opaque))
            color = spr_pixel.color;
        else if (bg_pixel.opaque)
            color = bg_pixel.color;
        else
            color = 8'd0;
    end

    assign {vga_r, vga_g, vga_b} = vga_de ? color : 8'd0;

    assert property (@(posedge vga_clk) disable iff (reset)
                     !beam.de |-> ##2 ({vga_r, vga_g, vga_b} == 8'd0))
        else $error("colour outside the active area");

endmodule

`default_nettype wire

// ==== verilog/gpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpu_top
(
    input  wire         vga_clk,
    input  wire         reset,
    input  wire         wr_en,
    input  wire  [11:0] wr_addr,
    input  wire  [31:0] wr_data,
    output logic [2:0]  vga_r,
    output logic [2:0]  vga_g,
    output logic [1:0]  vga_b,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_de
);

    video_timing_pkg::beam_t beam;
    tile_gfx_pkg::pixel_t    spr_pixel;
    tile_gfx_pkg::pixel_t    bg_pixel;
    logic                    spr_behind_bg;
    logic                    spr_req;
    logic                    spr_grant;
    logic [11:0]             spr_addr;
    logic                    bg_req;
    logic                    bg_grant;
    logic [11:0]             bg_addr;
    logic [31:0]             vram_rdata;   // shared by both renderers

    video_timing i_video_timing
    (
        .vga_clk (vga_clk),
        .reset   (reset),
        .beam    (beam)
    );

    vram_arbiter i_vram_arbiter
    (
        .vga_clk   (vga_clk),
        .reset     (reset),
        .spr_req   (spr_req),
        .spr_addr  (spr_addr),
        .spr_grant (spr_grant),
        .bg_req    (bg_req),
        .bg_addr   (bg_addr),
        .bg_grant  (bg_grant),
        .rdata     (vram_rdata),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    sprite_renderer i_sprite_renderer
    (
        .vga_clk    (vga_clk),
        .reset      (reset),
        .beam       (beam),
        .vram_req   (spr_req),
        .vram_addr  (spr_addr),
        .vram_grant (spr_grant),
        .vram_rdata (vram_rdata),
        .pixel      (spr_pixel),
        .behind_bg  (spr_behind_bg)
    );

    bg_renderer i_bg_renderer
    (
        .vga_clk    (vga_clk),
        .reset      (reset),
        .beam       (beam),
        .vram_req   (bg_req),
        .vram_addr  (bg_addr),
        .vram_grant (bg_grant),
        .vram_rdata (vram_rdata),
        .pixel      (bg_pixel)
    );

    pixel_mixer i_pixel_mixer
    (
        .vga_clk       (vga_clk),
        .reset         (reset),
        .beam          (beam),
        .spr_pixel     (spr_pixel),
        .spr_behind_bg (spr_behind_bg),
        .bg_pixel      (bg_pixel),
        .vga_r         (vga_r),
        .vga_g         (vga_g),
        .vga_b         (vga_b),
        .vga_hs        (vga_hs),
        .vga_vs        (vga_vs),
        .vga_de        (vga_de)
    );

endmodule

`default_nettype wire

// ==== test/gpu_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpu_monitor
(
    input wire       vga_clk,
    input wire       reset,
    input wire [2:0] vga_r,
    input wire [2:0] vga_g,
    input wire [1:0] vga_b,
    input wire       vga_hs,
    input wire       vga_vs,
    input wire       vga_de
);

    localparam int frame_pixels = video_timing_pkg::h_res * video_timing_pkg::v_res;

    int         exp_x [$];
    int         exp_y [$];
    logic [7:0] exp_c [$];
    bit         exp_seen [$];

    int   test_id        = 0;
    int   test_errors    = 0;
    int   test_checks    = 0;
    int   total_errors   = 0;
    int   total_checks   = 0;
    int   tests_done     = 0;
    int   frames_checked = 0;
    bit   armed          = 1'b0;
    bit   counting       = 1'b0;   // first frame after reset is not counted
    int   px             = 0;
    int   py             = 0;
    int   frame_count    = 0;
    logic prev_de        = 1'b0;
    logic prev_vs        = 1'b1;
    logic prev_hs        = 1'b1;
    bit   hs_seen        = 1'b0;
    int   hs_low         = 0;
    int   hs_high        = 0;
    int   hs_period      = 0;
    logic [7:0] color;

    assign color = {vga_r, vga_g, vga_b};

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic begin_test(input int n);
        test_id     = n;
        test_errors = 0;
        test_checks = 0;
        armed       = 1'b0;
        exp_x.delete();
        exp_y.delete();
        exp_c.delete();
        exp_seen.delete();
    endtask

    task automatic add_expect(input int x, input int y, input logic [7:0] c);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_c.push_back(c);
        exp_seen.push_back(1'b0);
    endtask

    task automatic arm_checks();
        armed = 1'b1;
    endtask

    task automatic end_test();
        armed = 1'b0;
        foreach (exp_x[i])
        begin
            if (!exp_seen[i])
            begin
                $display("test %0d: pixel (%0d,%0d) was never displayed", test_id,
                         exp_x[i], exp_y[i]);
                count_error();
            end
        end
        $display("test %0d: %0d checks, %0d errors", test_id, test_checks, test_errors);
        tests_done++;
    endtask

    task automatic report_counts();
        if (frames_checked == 0)
        begin
            $display("no complete frame was seen, pixel count never checked");
            total_errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", tests_done, total_checks, total_errors);
    endtask

    task automatic compare_pixel(input int x, input int y);
        foreach (exp_x[i])
        begin
            if (exp_x[i] == x && exp_y[i] == y && !exp_seen[i])
            begin
                exp_seen[i] = 1'b1;
                test_checks++;
                total_checks++;
                if (color !== exp_c[i])
                begin
                    $display("FAILED at %0t: pixel (%0d,%0d) is %h, expected %h", $time,
                             x, y, color, exp_c[i]);
                    count_error();
                end
            end
        end
    endtask

    always @(posedge vga_clk)
    begin
        if (reset)
        begin
            prev_de   = 1'b0;
            prev_vs   = 1'b1;
            prev_hs   = 1'b1;
            hs_seen   = 1'b0;
            hs_low    = 0;
            hs_high   = 0;
            hs_period = 0;
            px        = 0;
            py        = 0;
        end
        else
        begin
            if (prev_vs && !vga_vs)   // frame boundary
            begin
                if (counting)
                begin
                    frames_checked++;
                    total_checks++;
                    if (frame_count != frame_pixels)
                    begin
                        $display("FAILED at %0t: frame has %0d pixels, expected %0d", $time,
                                 frame_count, frame_pixels);
                        count_error();
                    end
                end
                counting    = 1'b1;
                frame_count = 0;
                px          = 0;
                py          = 0;
            end
            if (vga_de)
            begin
                if (armed)
                    compare_pixel(px, py);
                px++;
                frame_count++;
            end
            else
            begin
                if (prev_de)
                begin
                    px = 0;
                    py++;
                end
                if (color !== 8'd0)
                begin
                    $display("FAILED at %0t: colour %h outside the active area", $time, color);
                    count_error();
                end
            end

            // horizontal sync shape
            if (vga_de && !vga_hs)
            begin
                $display("FAILED at %0t: hsync low inside the active area", $time);
                count_error();
            end
            if (vga_de && !prev_de && hs_high != video_timing_pkg::h_bp)
            begin
                $display("FAILED at %0t: active area starts %0d cycles after hsync, expected %0d",
                         $time, hs_high, video_timing_pkg::h_bp);
                count_error();
            end
            if (prev_hs && !vga_hs)
            begin
                if (hs_seen && hs_period != video_timing_pkg::h_total)
                begin
                    $display("FAILED at %0t: hsync period is %0d cycles, expected %0d", $time,
                             hs_period, video_timing_pkg::h_total);
                    count_error();
                end
                hs_seen   = 1'b1;
                hs_period = 0;
            end
            if (!prev_hs && vga_hs && hs_low != video_timing_pkg::h_sync)
            begin
                $display("FAILED at %0t: hsync pulse is %0d cycles, expected %0d", $time,
                         hs_low, video_timing_pkg::h_sync);
                count_error();
            end
            hs_period++;
            if (vga_hs)
            begin
                hs_high++;
                hs_low = 0;
            end
            else
            begin
                hs_low++;
                hs_high = 0;
            end

            prev_de = vga_de;
            prev_vs = vga_vs;
            prev_hs = vga_hs;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_gpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_gpu_top;

    localparam int vs_timeout = 200000;   // one frame is 150150 cycles

    logic        vga_clk;
    logic        reset;
    logic        wr_en;
    logic [11:0] wr_addr;
    logic [31:0] wr_data;
    wire  [2:0]  vga_r;
    wire  [2:0]  vga_g;
    wire  [1:0]  vga_b;
    wire         vga_hs;
    wire         vga_vs;
    wire         vga_de;

    integer fd;
    integer code;
    string  line;
    byte    kind;
    int     n;
    int     addr;
    int     data;
    int     x;
    int     y;
    int     c;
    int     stim_errors = 0;

    gpu_top i_gpu_top
    (
        .vga_clk (vga_clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .vga_r   (vga_r),
        .vga_g   (vga_g),
        .vga_b   (vga_b),
        .vga_hs  (vga_hs),
        .vga_vs  (vga_vs),
        .vga_de  (vga_de)
    );

    gpu_monitor i_monitor
    (
        .vga_clk (vga_clk),
        .reset   (reset),
        .vga_r   (vga_r),
        .vga_g   (vga_g),
        .vga_b   (vga_b),
        .vga_hs  (vga_hs),
        .vga_vs  (vga_vs),
        .vga_de  (vga_de)
    );

    initial
    begin
        vga_clk = 1'b0;
        forever #2 vga_clk = ~vga_clk;
    end

    task automatic write_vram(input int a, input int d);
        @(posedge vga_clk);
        wr_en   <= 1'b1;
        wr_addr <= 12'(a);
        wr_data <= 32'(d);
    endtask

    task automatic wait_vs_fall();
        int   cycles;
        logic prev_vs;
        cycles = 0;
        @(posedge vga_clk);
        prev_vs = vga_vs;
        @(posedge vga_clk);
        while (!(prev_vs && !vga_vs) && cycles < vs_timeout)
        begin
            prev_vs = vga_vs;
            cycles++;
            @(posedge vga_clk);
        end
        if (cycles >= vs_timeout)
        begin
            $display("timeout: vertical sync did not fall within %0d cycles", vs_timeout);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    // second frame after the writes is the first one fully loaded
    task automatic run_frames();
        @(posedge vga_clk);
        wr_en <= 1'b0;
        wait_vs_fall();
        wait_vs_fall();
        i_monitor.arm_checks();
        wait_vs_fall();
        i_monitor.end_test();
    endtask

    initial
    begin
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (16) @(posedge vga_clk);
        reset <= 1'b0;
        fd = $fopen("test/gpu_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file test/gpu_stim.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(line, fd);
                kind = (code > 0 && line.len() > 0) ? line.getc(0) : "#";
                case (kind)
                    "t":
                    begin
                        code = $sscanf(line, "t %d", n);
                        i_monitor.begin_test(n);
                    end
                    "w":
                    begin
                        code = $sscanf(line, "w %h %h", addr, data);
                        if (code != 2)
                        begin
                            $display("bad write line in stimulus file: %s", line);
                            stim_errors++;
                        end
                        else
                            write_vram(addr, data);
                    end
                    "e":
                    begin
                        code = $sscanf(line, "e %d %d %h", x, y, c);
                        if (code != 3)
                        begin
                            $display("bad expect line in stimulus file: %s", line);
                            stim_errors++;
                        end
                        else
                            i_monitor.add_expect(x, y, 8'(c));
                    end
                    "r":
                        run_frames();
                    default: ;   // comments and blank lines
                endcase
            end
            $fclose(fd);
            i_monitor.report_counts();
            if (i_monitor.total_errors == 0 && stim_errors == 0 && i_monitor.tests_done > 0)
                $display("TEST RESULT: PASS");
            else
                $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/video_timing_pkg.sv
verilog/tile_gfx_pkg.sv
verilog/vram.sv
verilog/vram_arbiter.sv
verilog/video_timing.sv
verilog/sprite_renderer.sv
verilog/bg_renderer.sv
verilog/pixel_mixer.sv
verilog/gpu_top.sv
test/gpu_monitor.sv
test/tb_gpu_top.sv

// ==== Bender.yml ====
package:
  name: gpu_top

sources:
  - verilog/video_timing_pkg.sv
  - verilog/tile_gfx_pkg.sv
  - verilog/vram.sv
  - verilog/vram_arbiter.sv
  - verilog/video_timing.sv
  - verilog/sprite_renderer.sv
  - verilog/bg_renderer.sv
  - verilog/pixel_mixer.sv
  - verilog/gpu_top.sv
  - target: test
    files:
      - test/gpu_monitor.sv
      - test/tb_gpu_top.sv

// ==== test/gpu_stim.txt ====
# t <n>: start test n | w <addr hex> <data hex>: vram write
# e <x dec> <y dec> <rgb332 hex>: expected pixel | r: run frames and check
t 1
w 401 00E01C03
w 004 1B1B1B1B
w 005 1B1B1B1B
w 006 1B1B1B1B
w 007 1B1B1B1B
w 83E 01080000
e 16 8 00
e 17 8 E0
e 18 9 1C
e 19 12 03
e 20 15 00
e 21 15 E0
r
t 2
w 402 00FF9249
w 008 55425542
w 009 55425542
w 00A 55425542
w 00B 55425542
w 420 09050108
e 18 10 FF
e 22 14 FF
e 23 10 03
e 25 17 92
e 17 10 E0
e 18 9 1C
r
t 3
w 403 00000025
w 00C FF00FF00
w 00D FF00FF00
w 00E FF00FF00
w 00F FF00FF00
w 421 0A05018C
e 20 10 FF
e 22 12 FF
e 23 10 25
e 23 17 25
e 25 11 92
r
t 4
w 422 0801010A
w 423 08060109
e 16 8 FF
e 17 8 E0
e 20 9 FF
e 23 9 03
e 16 12 00
e 17 13 E0
r
t 5
r
